/* include/ntt_cfg.svh */
/*
 * Configuration macros for the masked inverse-NTT butterfly:
 * modulus, coefficient width, multiplier pipeline depth and
 * output buffer depth.
 */

`ifndef NTT_CFG_SVH
`define NTT_CFG_SVH

// ML-DSA prime, 2^23 - 2^13 + 1
`define NTT_Q 23'd8380417

// one coefficient modulo q
`define NTT_COEFF_W 23

// multiplier depth: product stage plus reduction stages, at least 2
`define NTT_MUL_STAGES 3

// result FIFO entries
`define NTT_OBUF_DEPTH 2

`endif

/* rtl/butterfly_out_buffer.sv */
/*
 * Result FIFO on the output handshake.
 * Also produces the pipeline advance, so a result never
 * arrives while every entry is taken.
 */

`timescale 1ns/10ps

`include "ntt_cfg.svh"

module butterfly_out_buffer (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize_i,
    input  logic                     valid_i,
    input  ntt_masked_pkg::bfu_out_t data_i,
    output logic                     advance_o,
    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output ntt_masked_pkg::bfu_out_t out_data_o
);

    import ntt_masked_pkg::*;

    localparam int DEPTH = `NTT_OBUF_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    bfu_out_t         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // full is fine as long as the head leaves this cycle
    assign advance_o   = (count_q != CNT_W'(DEPTH)) || out_ready_i;
    assign out_valid_o = (count_q != '0);
    assign out_data_o  = mem_q[rd_ptr_q];

    assign push = valid_i && advance_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else if (zeroize_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else begin
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // entries hold shares, cleared on zeroize
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end
        else if (zeroize_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end
        else if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

/* rtl/masked_mod_mult.sv */
/*
 * Pipelined multiply of one share by the public twiddle mod q.
 * First stage forms the full product, the remaining stages fold
 * with 2^23 = 8191 mod q and finish with one conditional subtract.
 */

`timescale 1ns/10ps

`include "ntt_cfg.svh"

module masked_mod_mult (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize_i,
    input  logic                   advance_i,
    input  ntt_masked_pkg::coeff_t a_i,
    input  ntt_masked_pkg::coeff_t w_i,
    output ntt_masked_pkg::coeff_t p_o
);

    import ntt_masked_pkg::*;

    localparam int COEFF_W    = `NTT_COEFF_W;
    localparam int PROD_W     = 2 * COEFF_W;
    localparam int RED_STAGES = `NTT_MUL_STAGES - 1;

    localparam logic [PROD_W-1:0] FOLD_K = PROD_W'((1 << COEFF_W) - `NTT_Q);
    localparam logic [PROD_W-1:0] Q_EXT  = PROD_W'(`NTT_Q);

    logic [PROD_W-1:0] prod_q;
    logic [PROD_W-1:0] red_q [RED_STAGES];
    logic [PROD_W-1:0] red_d [RED_STAGES];

    // x = hi*2^23 + lo  ->  hi*8191 + lo
    function automatic logic [PROD_W-1:0] fold(input logic [PROD_W-1:0] x);
        return PROD_W'(x[PROD_W-1:COEFF_W]) * FOLD_K + PROD_W'(x[COEFF_W-1:0]);
    endfunction

    function automatic logic [PROD_W-1:0] cond_sub(input logic [PROD_W-1:0] x);
        return (x >= Q_EXT) ? x - Q_EXT : x;
    endfunction

    // two folds take 46 bits below 2^28, two more below 2^23 + 8191
    // a fold of a value already under 2^23 leaves it unchanged
    for (genvar s = 0; s < RED_STAGES; s++) begin : g_red
        logic [PROD_W-1:0] partial;
        if (s == 0) begin : g_first
            assign partial = fold(fold(prod_q));
        end
        else begin : g_pass
            assign partial = red_q[s-1];
        end
        if (s == RED_STAGES - 1) begin : g_last
            assign red_d[s] = cond_sub(fold(fold(partial)));
        end
        else begin : g_keep
            assign red_d[s] = partial;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
            for (int s = 0; s < RED_STAGES; s++) begin
                red_q[s] <= '0;
            end
        end
        else if (zeroize_i) begin
            prod_q <= '0;
            for (int s = 0; s < RED_STAGES; s++) begin
                red_q[s] <= '0;
            end
        end
        else if (advance_i) begin
            prod_q <= PROD_W'(a_i) * PROD_W'(w_i);
            for (int s = 0; s < RED_STAGES; s++) begin
                red_q[s] <= red_d[s];
            end
        end
    end

    assign p_o = coeff_t'(red_q[RED_STAGES-1][COEFF_W-1:0]);

endmodule

/* rtl/masked_operand_in.sv */
/*
 * Input holding register with valid/ready.
 * Refreshes the masks of u and v with the fresh random word
 * as the operation is captured.
 */

`timescale 1ns/10ps

`include "ntt_cfg.svh"

module masked_operand_in (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize_i,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  ntt_masked_pkg::bfu_in_t in_data_i,
    input  logic                    advance_i,
    output logic                    op_valid_o,
    output ntt_masked_pkg::bfu_in_t op_data_o
);

    import ntt_masked_pkg::*;

    logic    valid_q;
    bfu_in_t data_q;
    logic    capture;

    // a held operation leaves on advance, so a new one may enter then
    assign in_ready_o = advance_i || !valid_q;
    assign capture    = in_valid_i && in_ready_o;

    assign op_valid_o = valid_q;
    assign op_data_o  = data_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
            data_q  <= '0;
        end
        else if (zeroize_i) begin
            valid_q <= 1'b0;
            data_q  <= '0;
        end
        else if (capture) begin
            valid_q <= 1'b1;
            // +rnd on share0, -rnd on share1 keeps each unmasked value
            data_q.u.share0 <= mod_add(in_data_i.u.share0, in_data_i.rnd);
            data_q.u.share1 <= mod_sub(in_data_i.u.share1, in_data_i.rnd);
            data_q.v.share0 <= mod_add(in_data_i.v.share0, in_data_i.rnd);
            data_q.v.share1 <= mod_sub(in_data_i.v.share1, in_data_i.rnd);
            data_q.w        <= in_data_i.w;
            data_q.rnd      <= in_data_i.rnd;
        end
        else if (advance_i) begin
            valid_q <= 1'b0;
        end
    end

endmodule

/* rtl/ntt_masked_bfu_top.sv */
/*
 * Masked inverse-NTT butterfly unit: input register with mask
 * refresh, pipelined butterfly, output FIFO.
 */

`timescale 1ns/10ps

`include "ntt_cfg.svh"

module ntt_masked_bfu_top (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize_i,
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  ntt_masked_pkg::bfu_in_t  in_data_i,
    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output ntt_masked_pkg::bfu_out_t out_data_o
);

    import ntt_masked_pkg::*;

    // whole pipeline moves together on advance
    logic     advance;
    logic     op_valid;
    bfu_in_t  op_data;
    logic     res_valid;
    bfu_out_t res_data;

    masked_operand_in operand_in_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize_i  (zeroize_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .in_data_i  (in_data_i),
        .advance_i  (advance),
        .op_valid_o (op_valid),
        .op_data_o  (op_data)
    );

    ntt_masked_gs_butterfly butterfly_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .advance_i (advance),
        .valid_i   (op_valid),
        .data_i    (op_data),
        .valid_o   (res_valid),
        .data_o    (res_data)
    );

    butterfly_out_buffer out_buffer_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .valid_i     (res_valid),
        .data_i      (res_data),
        .advance_o   (advance),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_data_o)
    );

endmodule

/* rtl/ntt_masked_gs_butterfly.sv */
/*
 * Masked Gentleman-Sande butterfly, two arithmetic shares.
 * u' = u + v and v' = (u - v) * w, each mod q, share by share.
 * The twiddle is public, so each share is multiplied on its own.
 */

`timescale 1ns/10ps

`include "ntt_cfg.svh"

module ntt_masked_gs_butterfly (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize_i,
    input  logic                     advance_i,
    input  logic                     valid_i,
    input  ntt_masked_pkg::bfu_in_t  data_i,
    output logic                     valid_o,
    output ntt_masked_pkg::bfu_out_t data_o
);

    import ntt_masked_pkg::*;

    localparam int DLY = `NTT_MUL_STAGES;

    logic          s1_valid_q;
    masked_coeff_t s1_sum_q;
    masked_coeff_t s1_diff_q;
    coeff_t        s1_w_q;

    logic [DLY-1:0] dly_valid_q;
    masked_coeff_t  dly_sum_q [DLY];

    coeff_t prod0;
    coeff_t prod1;

    // stage 1: share-wise add/sub, twiddle lined up with the difference
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid_q <= 1'b0;
            s1_sum_q   <= '0;
            s1_diff_q  <= '0;
            s1_w_q     <= '0;
        end
        else if (zeroize_i) begin
            s1_valid_q <= 1'b0;
            s1_sum_q   <= '0;
            s1_diff_q  <= '0;
            s1_w_q     <= '0;
        end
        else if (advance_i) begin
            s1_valid_q       <= valid_i;
            s1_sum_q.share0  <= mod_add(data_i.u.share0, data_i.v.share0);
            s1_sum_q.share1  <= mod_add(data_i.u.share1, data_i.v.share1);
            s1_diff_q.share0 <= mod_sub(data_i.u.share0, data_i.v.share0);
            s1_diff_q.share1 <= mod_sub(data_i.u.share1, data_i.v.share1);
            s1_w_q           <= data_i.w;
        end
    end

    masked_mod_mult mult_share0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .advance_i (advance_i),
        .a_i       (s1_diff_q.share0),
        .w_i       (s1_w_q),
        .p_o       (prod0)
    );

    masked_mod_mult mult_share1 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .advance_i (advance_i),
        .a_i       (s1_diff_q.share1),
        .w_i       (s1_w_q),
        .p_o       (prod1)
    );

    // sum and valid wait beside the multipliers, then the output register
    // halving by two is left to the caller
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dly_valid_q <= '0;
            for (int i = 0; i < DLY; i++) begin
                dly_sum_q[i] <= '0;
            end
            valid_o <= 1'b0;
            data_o  <= '0;
        end
        else if (zeroize_i) begin
            dly_valid_q <= '0;
            for (int i = 0; i < DLY; i++) begin
                dly_sum_q[i] <= '0;
            end
            valid_o <= 1'b0;
            data_o  <= '0;
        end
        else if (advance_i) begin
            dly_valid_q  <= {dly_valid_q[DLY-2:0], s1_valid_q};
            dly_sum_q[0] <= s1_sum_q;
            for (int i = 1; i < DLY; i++) begin
                dly_sum_q[i] <= dly_sum_q[i-1];
            end
            valid_o         <= dly_valid_q[DLY-1];
            data_o.u        <= dly_sum_q[DLY-1];
            data_o.v.share0 <= prod0;
            data_o.v.share1 <= prod1;
        end
    end

endmodule

/* rtl/ntt_masked_pkg.sv */
/*
 * Types for the masked butterfly: coefficient, two-share pair,
 * input and output bundles, and the modular add/sub helpers
 * shared by the input stage and the butterfly.
 */

`include "ntt_cfg.svh"

package ntt_masked_pkg;

    typedef logic [`NTT_COEFF_W-1:0] coeff_t;

    // value carried is share0 + share1 mod q
    typedef struct packed {
        coeff_t share0;
        coeff_t share1;
    } masked_coeff_t;

    typedef struct packed {
        masked_coeff_t u;
        masked_coeff_t v;
        coeff_t        w;
        coeff_t        rnd;
    } bfu_in_t;

    typedef struct packed {
        masked_coeff_t u;
        masked_coeff_t v;
    } bfu_out_t;

    // operands are already reduced, so one correction is enough
    function automatic coeff_t mod_add(input coeff_t a, input coeff_t b);
        logic [`NTT_COEFF_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, `NTT_Q}) begin
            s = s - {1'b0, `NTT_Q};
        end
        return s[`NTT_COEFF_W-1:0];
    endfunction

    function automatic coeff_t mod_sub(input coeff_t a, input coeff_t b);
        logic [`NTT_COEFF_W:0] d;
        d = {1'b0, a} - {1'b0, b};
        if (a < b) begin
            d = d + {1'b0, `NTT_Q};
        end
        return d[`NTT_COEFF_W-1:0];
    endfunction

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the masked butterfly testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module ntt_masked_bfu_tb -f sources.f -o bfu_sim

output=$(./obj_dir/bfu_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF 'All tests passed!'; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi

/* sim/bfu_trace.txt */
# one operation per line, decimal: u.share0 u.share1 v.share0 v.share1 w rnd
# then the expected unmasked results u+v and (u-v)*w, both mod q
1 2 3 4 5 0 10 8380397
10 20 1 2 3 7 33 81
100 200 50 25 0 123 375 0
1000 0 1 0 8380416 5 1001 8379418
8380416 1 0 0 2 9 0 0
8380416 8380416 5 5 1 1 8 8380405
0 0 1 0 8380416 8380416 1 1
4000000 4000000 300000 100000 2 42 19583 6819583
123456 0 0 0 1000 1000 123456 6130162
7 8 9 10 11 8000000 34 8380373
2 3 2 3 777 0 10 0
65536 0 0 1 65536 3 65537 4128256
1 0 0 0 8380416 77 1 8380416
0 0 0 0 0 0 0 0
8380416 0 8380416 0 5 100 8380415 0
0 0 8380416 0 8380416 200 8380416 8380416
3000 0 0 1000 3000 11 4000 6000000
5 0 10 0 1000000 13 15 3380417
100000 100000 0 0 100 14 200000 3239166
1 1 1 1 1 8380416 4 0
8380000 0 0 1000 1 16 583 8379000
50 0 8380000 0 2 17 8380050 934
12345 54321 11111 22222 10 18 99999 333330
999 1 0 0 8380416 19 1000 8379417
0 2000000 0 1 5 20 2000001 1619578
4 4 4 4 8380416 21 16 0
6000000 0 3000000 0 3 22 619583 619583
1 0 2 0 1 23 3 8380416
256 0 0 0 256 24 256 65536
8380415 1 1 0 8380416 25 0 2

/* sim/ntt_masked_bfu_asserts.sv */
/*
 * Concurrent checks on the input and output handshakes
 * of the butterfly unit, bound to the top level.
 */

`timescale 1ns/10ps

module ntt_masked_bfu_asserts (
    input logic                     clk,
    input logic                     reset_n,
    input logic                     zeroize_i,
    input logic                     in_valid_i,
    input logic                     in_ready_o,
    input ntt_masked_pkg::bfu_in_t  in_data_i,
    input logic                     out_valid_o,
    input logic                     out_ready_i,
    input ntt_masked_pkg::bfu_out_t out_data_o
);

    // a stalled result keeps its data and its valid
    out_data_stable: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid_o && !out_ready_i && !zeroize_i |=> $stable(out_data_o))
        else $error("out_data_o changed while waiting for out_ready_i");

    out_valid_held: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid_o && !out_ready_i && !zeroize_i |=> out_valid_o)
        else $error("out_valid_o dropped before out_ready_i");

    // source side must hold an offered operation
    in_data_held: assert property (@(posedge clk) disable iff (!reset_n)
        in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_data_i))
        else $error("input operation withdrawn or changed before in_ready_o");

    out_idle_after_reset: assert property (@(posedge clk)
        $rose(reset_n) |-> !out_valid_o && in_ready_o)
        else $error("unit not idle when reset is released");

    out_idle_after_zeroize: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |=> !out_valid_o)
        else $error("out_valid_o high right after zeroize");

endmodule

/* sim/ntt_masked_bfu_tb.sv */
/*
 * Testbench for the masked butterfly unit.
 * Trace driven stimulus, in-order scoreboard, random output stalls,
 * zeroize with operations in flight, latency check and timeout.
 */

`timescale 1ns/10ps

module ntt_masked_bfu_tb;

    import ntt_masked_pkg::*;

    localparam longint unsigned Q = 64'd8380417;
    localparam int MAX_OPS    = 64;
    localparam int READY_LOW  = 0;
    localparam int READY_HIGH = 1;
    localparam int READY_RAND = 2;

    logic     clk;
    logic     reset_n;
    logic     zeroize_i;
    logic     in_valid_i;
    logic     in_ready_o;
    bfu_in_t  in_data_i;
    logic     out_valid_o;
    logic     out_ready_i;
    bfu_out_t out_data_o;

    bfu_in_t         tr_in [MAX_OPS];
    longint unsigned exp_u [MAX_OPS];
    longint unsigned exp_v [MAX_OPS];
    int              acc_cycle [MAX_OPS];
    int              expect_q [$];
    int              n_ops = 0;
    int              n_in = 0;
    int              n_out = 0;
    int              n_dropped = 0;
    int              cur_idx = 0;
    int              cycle_cnt = 0;
    int              timeout_limit = 1000;
    int              ready_mode = READY_LOW;
    bit              latency_mode = 1'b0;
    int              seed = 17;
    logic [31:0]     rnd_word;

    ntt_masked_bfu_top ntt_masked_bfu_top_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (in_data_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_data_o)
    );

    bind ntt_masked_bfu_top ntt_masked_bfu_asserts bfu_asserts_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (in_data_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    function automatic longint unsigned unmask(input masked_coeff_t m);
        return (64'(m.share0) + 64'(m.share1)) % Q;
    endfunction

    // GS butterfly on the plain values, u+v and (u-v)*w
    function automatic longint unsigned model_u(input bfu_in_t op);
        return (unmask(op.u) + unmask(op.v)) % Q;
    endfunction

    function automatic longint unsigned model_v(input bfu_in_t op);
        return ((unmask(op.u) + Q - unmask(op.v)) % Q) * 64'(op.w) % Q;
    endfunction

    task automatic load_trace();
        int          fd;
        int          nread;
        string       line;
        int unsigned f [8];
        fd = $fopen("sim/bfu_trace.txt", "r");
        assert (fd != 0) else
            stop_on_error("Cannot open the trace file sim/bfu_trace.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                nread = $sscanf(line, "%d %d %d %d %d %d %d %d",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                assert (nread == 8 && n_ops < MAX_OPS) else
                    stop_on_error($sformatf("Trace line cannot be read: %s", line));
                tr_in[n_ops].u.share0 = coeff_t'(f[0]);
                tr_in[n_ops].u.share1 = coeff_t'(f[1]);
                tr_in[n_ops].v.share0 = coeff_t'(f[2]);
                tr_in[n_ops].v.share1 = coeff_t'(f[3]);
                tr_in[n_ops].w        = coeff_t'(f[4]);
                tr_in[n_ops].rnd      = coeff_t'(f[5]);
                exp_u[n_ops] = 64'(f[6]);
                exp_v[n_ops] = 64'(f[7]);
                assert (model_u(tr_in[n_ops]) == exp_u[n_ops] &&
                        model_v(tr_in[n_ops]) == exp_v[n_ops]) else
                    stop_on_error($sformatf("Mismatch at %0t: trace op %0d breaks the rule",
                                            $time, n_ops));
                n_ops++;
            end
        end
        $fclose(fd);
        assert (n_ops >= 11) else
            stop_on_error("The trace holds too few operations for the test sequence");
        timeout_limit = 20 * (n_ops + 10);
    endtask

    // holds the operation until taken, returns 1 ns after that edge
    task automatic send_op(input int idx);
        logic taken;
        cur_idx    = idx;
        in_data_i  = tr_in[idx];
        in_valid_i = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready_o;
            @(posedge clk);
        end
        #1;
        in_valid_i = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_drain();
        while (expect_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic set_ready_mode(input int mode);
        @(posedge clk);
        ready_mode = mode;
        #1;
    endtask

    task automatic check_output();
        int              idx;
        longint unsigned got_u;
        longint unsigned got_v;
        assert (expect_q.size() != 0) else
            stop_on_error("An output was delivered with no operation in flight");
        idx   = expect_q.pop_front();
        got_u = unmask(out_data_o.u);
        got_v = unmask(out_data_o.v);
        n_out++;
        assert (64'(out_data_o.u.share0) < Q && 64'(out_data_o.u.share1) < Q &&
                64'(out_data_o.v.share0) < Q && 64'(out_data_o.v.share1) < Q) else
            stop_on_error($sformatf("Mismatch at %0t: op %0d has a share not below q",
                                    $time, idx));
        assert (got_u == exp_u[idx]) else
            stop_on_error($sformatf("Mismatch at %0t: op %0d u is %0d, expected %0d",
                                    $time, idx, got_u, exp_u[idx]));
        assert (got_v == exp_v[idx]) else
            stop_on_error($sformatf("Mismatch at %0t: op %0d v is %0d, expected %0d",
                                    $time, idx, got_v, exp_v[idx]));
        if (latency_mode) begin
            assert (cycle_cnt - acc_cycle[idx] == 7) else
                stop_on_error($sformatf("Mismatch at %0t: op %0d took %0d cycles, expected 7",
                                        $time, idx, cycle_cnt - acc_cycle[idx]));
        end
    endtask

    // sink side, drives out_ready_i after each edge
    always @(posedge clk) begin
        #1;
        if (ready_mode == READY_RAND) begin
            rnd_word    = $random(seed);
            out_ready_i = rnd_word[0];
        end
        else begin
            out_ready_i = (ready_mode == READY_HIGH);
        end
    end

    // handshakes sampled mid-cycle, they decide the next rising edge
    always @(negedge clk) begin
        cycle_cnt++;
        assert (cycle_cnt < timeout_limit) else
            stop_on_error($sformatf("Timeout: the test did not finish in %0d cycles",
                                    timeout_limit));
        if (reset_n && zeroize_i) begin
            n_dropped += expect_q.size();
            expect_q.delete();
        end
        else if (reset_n) begin
            if (out_valid_o && out_ready_i) begin
                check_output();
            end
            if (in_valid_i && in_ready_o) begin
                acc_cycle[cur_idx] = cycle_cnt;
                expect_q.push_back(cur_idx);
                n_in++;
            end
        end
    end

    initial begin
        reset_n     = 1'b0;
        zeroize_i   = 1'b0;
        in_valid_i  = 1'b0;
        in_data_i   = '0;
        out_ready_i = 1'b0;
        load_trace();
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        @(negedge clk);
        assert (!out_valid_o && in_ready_o) else
            stop_on_error("After reset out_valid_o is not low or in_ready_o is not high");
        @(posedge clk);
        #1;

        // back to back, sink always ready
        set_ready_mode(READY_HIGH);
        latency_mode = 1'b1;
        for (int i = 0; i < 8; i++) begin
            send_op(i);
        end
        wait_drain();
        latency_mode = 1'b0;
        for (int i = 1; i < 8; i++) begin
            assert (acc_cycle[i] == acc_cycle[i-1] + 1) else
                stop_on_error($sformatf("Mismatch at %0t: op %0d not accepted right after op %0d",
                                        $time, i, i - 1));
        end

        // three operations still inside the pipeline when zeroize hits
        for (int i = 8; i < 11; i++) begin
            send_op(i);
        end
        wait_cycles(2);
        zeroize_i = 1'b1;
        wait_cycles(1);
        zeroize_i = 1'b0;
        repeat (12) begin
            @(negedge clk);
            assert (!out_valid_o && in_ready_o) else
                stop_on_error("An output appeared or the input was blocked after zeroize");
        end
        @(posedge clk);
        #1;

        // rest of the trace with a stalling sink
        set_ready_mode(READY_RAND);
        for (int i = 8; i < n_ops; i++) begin
            send_op(i);
        end
        wait_drain();
        wait_cycles(10);

        assert (n_dropped == 3 && n_out + n_dropped == n_in && n_in == n_ops + 3) else
            stop_on_error($sformatf("Output count is wrong: %0d in, %0d out, %0d dropped",
                                    n_in, n_out, n_dropped));
        $display("All tests passed!");
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
rtl/ntt_masked_pkg.sv
rtl/masked_operand_in.sv
rtl/masked_mod_mult.sv
rtl/ntt_masked_gs_butterfly.sv
rtl/butterfly_out_buffer.sv
rtl/ntt_masked_bfu_top.sv
sim/ntt_masked_bfu_asserts.sv
sim/ntt_masked_bfu_tb.sv
